// ==== verilog/tetris_pkg.sv ====
package tetris_pkg;

	//============================================================
	// board geometry and counter widths
	//============================================================
	localparam int BOARD_ROWS      = 20; // row 0 is the top
	localparam int BOARD_COLS      = 10;
	localparam int ROW_W           = 5;
	localparam int COL_W           = 4;
	localparam int LINES_W         = 10;
	localparam int LEVEL_W         = 6;
	localparam int LINES_PER_LEVEL = 10;

	typedef logic [BOARD_COLS-1:0] row_bits_t; // bit c is column c

	typedef enum logic [2:0] {
		T = 3'd1,
		O = 3'd2,
		L = 3'd3,
		J = 3'd4,
		S = 3'd5,
		Z = 3'd6,
		I = 3'd7
	} piece_e;

	typedef enum logic [1:0] {
		IDLE,
		DROPPING,
		CLEARING,
		OVER
	} game_state_e;

	typedef struct packed {
		logic [ROW_W-1:0] rd_row;
		logic             wr_en;
		logic [ROW_W-1:0] wr_row;
		row_bits_t        wr_bits;
	} mem_req_t;

	typedef struct packed {
		row_bits_t top;
		row_bits_t bottom;
	} piece_mask_t;

	function automatic logic [COL_W-1:0] piece_width(piece_e p);
		case (p)
			I:       return 4'd4;
			O:       return 4'd2;
			default: return 4'd3;
		endcase
	endfunction

	// spawn orientation, left aligned
	function automatic piece_mask_t piece_mask(piece_e p);
		piece_mask_t m;
		m = '0;
		case (p)
			I: m.bottom = 10'b00_0000_1111;
			T: begin
				m.top    = 10'b00_0000_0010;
				m.bottom = 10'b00_0000_0111;
			end
			O: begin
				m.top    = 10'b00_0000_0011;
				m.bottom = 10'b00_0000_0011;
			end
			L: begin
				m.top    = 10'b00_0000_0100;
				m.bottom = 10'b00_0000_0111;
			end
			J: begin
				m.top    = 10'b00_0000_0001;
				m.bottom = 10'b00_0000_0111;
			end
			S: begin
				m.top    = 10'b00_0000_0110;
				m.bottom = 10'b00_0000_0011;
			end
			Z: begin
				m.top    = 10'b00_0000_0011;
				m.bottom = 10'b00_0000_0110;
			end
			default: m = '0;
		endcase
		return m;
	endfunction

endpackage

// ==== verilog/playfield_ram.sv ====
`timescale 1ns/1ps

module playfield_ram (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 clr,
	input  tetris_pkg::mem_req_t req,
	output tetris_pkg::row_bits_t rd_bits
);
	import tetris_pkg::*;

	row_bits_t rows [BOARD_ROWS]; // one word per board row

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < BOARD_ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (clr) begin // whole board in one cycle
			for (int r = 0; r < BOARD_ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (req.wr_en) begin
			rows[req.wr_row] <= req.wr_bits;
		end
	end

	assign rd_bits = rows[req.rd_row]; // combinational read

	// requests reach here through the game_ctrl mux from either worker
	assert property (@(posedge clk) disable iff (!rst_n)
		(req.rd_row < ROW_W'(BOARD_ROWS)) &&
		(!req.wr_en || (req.wr_row < ROW_W'(BOARD_ROWS))))
		else $error("playfield row index out of range");

endmodule

// ==== verilog/piece_dropper.sv ====
`timescale 1ns/1ps

module piece_dropper (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        go,
	input  tetris_pkg::piece_e          piece,
	input  logic [tetris_pkg::COL_W-1:0] column,
	input  tetris_pkg::row_bits_t       rd_bits,
	output tetris_pkg::mem_req_t        req,
	output logic                        done,
	output logic                        spawn_fail
);
	import tetris_pkg::*;

	typedef enum logic [2:0] {
		D_IDLE,
		D_RD_TOP,
		D_RD_BOT,
		D_LK_TOP,
		D_LK_BOT
	} drop_state_e;

	drop_state_e      state;
	piece_mask_t      raw;
	piece_mask_t      mask;    // footprint shifted to its column
	logic [ROW_W-1:0] pos;     // top row of the candidate
	logic             top_hit;
	logic             hit;
	logic             pending;

	assign raw = piece_mask(piece);
	assign hit = top_hit | (|(rd_bits & mask.bottom));

	always_ff @(posedge clk) begin
		if (state == D_IDLE && go) begin
			mask.top    <= raw.top << column;
			mask.bottom <= raw.bottom << column;
		end
	end

	//============================================================
	// memory side, read-modify-write while locking
	//============================================================
	always_comb begin
		req = '0;
		case (state)
			D_RD_TOP: req.rd_row = pos;
			D_RD_BOT: req.rd_row = pos + ROW_W'(1);
			D_LK_TOP: begin
				req.rd_row  = pos;
				req.wr_en   = 1'b1;
				req.wr_row  = pos;
				req.wr_bits = rd_bits | mask.top;
			end
			D_LK_BOT: begin
				req.rd_row  = pos + ROW_W'(1);
				req.wr_en   = 1'b1;
				req.wr_row  = pos + ROW_W'(1);
				req.wr_bits = rd_bits | mask.bottom;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= D_IDLE;
			pos        <= '0;
			top_hit    <= 1'b0;
			done       <= 1'b0;
			spawn_fail <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				D_IDLE: if (go) begin
					pos        <= '0; // spawn position
					spawn_fail <= 1'b0;
					state      <= D_RD_TOP;
				end
				D_RD_TOP: begin
					top_hit <= |(rd_bits & mask.top);
					state   <= D_RD_BOT;
				end
				D_RD_BOT: begin
					if (hit && pos == '0) begin
						spawn_fail <= 1'b1; // nothing gets written
						done       <= 1'b1;
						state      <= D_IDLE;
					end else if (hit) begin
						pos   <= pos - ROW_W'(1); // back to last free spot
						state <= D_LK_TOP;
					end else if (pos == ROW_W'(BOARD_ROWS - 2)) begin
						state <= D_LK_TOP; // resting on the floor
					end else begin
						pos   <= pos + ROW_W'(1);
						state <= D_RD_TOP;
					end
				end
				D_LK_TOP: state <= D_LK_BOT;
				D_LK_BOT: begin
					done  <= 1'b1;
					state <= D_IDLE;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (go)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> pending)
		else $error("drop done without a preceding go");

endmodule

// ==== verilog/line_clearer.sv ====
`timescale 1ns/1ps

module line_clearer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  go,
	input  tetris_pkg::row_bits_t rd_bits,
	output tetris_pkg::mem_req_t  req,
	output logic                  done,
	output logic [2:0]            cleared
);
	import tetris_pkg::*;

	typedef enum logic [1:0] {
		C_IDLE,
		C_SCAN,
		C_FILL
	} clear_state_e;

	clear_state_e     state;
	logic [ROW_W-1:0] rd_ptr;
	logic [ROW_W-1:0] wr_ptr;
	logic             full;

	assign full = &rd_bits;

	always_comb begin
		req = '0;
		case (state)
			C_SCAN: begin
				req.rd_row  = rd_ptr;
				req.wr_en   = !full && (rd_ptr != wr_ptr); // pull row down
				req.wr_row  = wr_ptr;
				req.wr_bits = rd_bits;
			end
			C_FILL: begin
				req.rd_row = wr_ptr;
				req.wr_en  = 1'b1; // vacated top row
				req.wr_row = wr_ptr;
			end
			default: ;
		endcase
	end

	//============================================================
	// bottom-up scan, then zero fill
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= C_IDLE;
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			cleared <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				C_IDLE: if (go) begin
					rd_ptr  <= ROW_W'(BOARD_ROWS - 1);
					wr_ptr  <= ROW_W'(BOARD_ROWS - 1);
					cleared <= '0;
					state   <= C_SCAN;
				end
				C_SCAN: begin
					if (full)
						cleared <= cleared + 3'd1; // skipped
					else
						wr_ptr <= wr_ptr - ROW_W'(1);
					if (rd_ptr != '0) begin
						rd_ptr <= rd_ptr - ROW_W'(1);
					end else if (full || cleared != '0) begin
						state <= C_FILL;
					end else begin
						done  <= 1'b1;
						state <= C_IDLE;
					end
				end
				C_FILL: begin
					if (wr_ptr == '0) begin
						done  <= 1'b1;
						state <= C_IDLE;
					end else begin
						wr_ptr <= wr_ptr - ROW_W'(1);
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	// a locked piece spans two rows, so no more than two can fill at once
	assert property (@(posedge clk) disable iff (!rst_n) done |-> cleared <= 3'd2)
		else $error("more than two rows cleared after one drop");

endmodule

// ==== verilog/game_ctrl.sv ====
`timescale 1ns/1ps

module game_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            drop,
	input  tetris_pkg::piece_e              piece,
	input  logic [tetris_pkg::COL_W-1:0]    column,
	input  logic                            restart,
	input  logic [tetris_pkg::ROW_W-1:0]    rd_row,
	input  tetris_pkg::mem_req_t            drop_req,
	input  tetris_pkg::mem_req_t            clear_req,
	input  logic                            drop_done,
	input  logic                            spawn_fail,
	input  logic                            clear_done,
	input  logic [2:0]                      cleared,
	output logic                            drop_go,
	output logic                            clear_go,
	output logic                            clr,
	output tetris_pkg::mem_req_t            mem_req,
	output tetris_pkg::piece_e              drop_piece,
	output logic [tetris_pkg::COL_W-1:0]    drop_col,
	output logic                            busy,
	output logic                            game_over,
	output logic [tetris_pkg::LINES_W-1:0]  lines,
	output logic [tetris_pkg::LEVEL_W-1:0]  level
);
	import tetris_pkg::*;

	game_state_e      state;
	logic [COL_W-1:0] col_max;
	logic [3:0]       lines_left; // lines still needed for the next level
	logic             accept;

	assign col_max   = COL_W'(BOARD_COLS) - piece_width(piece);
	assign accept    = (state == IDLE) && drop;
	assign clr       = (state == OVER) && restart;
	assign busy      = (state == DROPPING) || (state == CLEARING);
	assign game_over = (state == OVER);

	always_ff @(posedge clk) begin
		if (accept) begin
			drop_piece <= piece;
			drop_col   <= (column > col_max) ? col_max : column; // clamp
		end
	end

	// the worker that owns the state gets the memory
	always_comb begin
		case (state)
			DROPPING: mem_req = drop_req;
			CLEARING: mem_req = clear_req;
			default: begin
				mem_req        = '0;
				mem_req.rd_row = rd_row; // host readout
			end
		endcase
	end

	//============================================================
	// game FSM and counters
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			drop_go    <= 1'b0;
			clear_go   <= 1'b0;
			lines      <= '0;
			level      <= '0;
			lines_left <= 4'(LINES_PER_LEVEL);
		end else begin
			drop_go  <= 1'b0;
			clear_go <= 1'b0;
			case (state)
				IDLE: if (accept) begin
					drop_go <= 1'b1;
					state   <= DROPPING;
				end
				DROPPING: if (drop_done) begin
					if (spawn_fail) begin
						state <= OVER;
					end else begin
						clear_go <= 1'b1;
						state    <= CLEARING;
					end
				end
				CLEARING: if (clear_done) begin
					lines <= lines + LINES_W'(cleared);
					if (4'(cleared) >= lines_left) begin
						level      <= level + LEVEL_W'(1);
						lines_left <= lines_left + 4'(LINES_PER_LEVEL) - 4'(cleared);
					end else begin
						lines_left <= lines_left - 4'(cleared);
					end
					state <= IDLE;
				end
				OVER: if (restart) begin
					lines      <= '0;
					level      <= '0;
					lines_left <= 4'(LINES_PER_LEVEL);
					state      <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/tetris_core.sv ====
`timescale 1ns/1ps

module tetris_core (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           drop,
	input  tetris_pkg::piece_e             piece,
	input  logic [tetris_pkg::COL_W-1:0]   column,
	input  logic                           restart,
	input  logic [tetris_pkg::ROW_W-1:0]   rd_row,
	output logic                           busy,
	output logic                           game_over,
	output logic [tetris_pkg::LINES_W-1:0] lines,
	output logic [tetris_pkg::LEVEL_W-1:0] level,
	output tetris_pkg::row_bits_t          rd_bits
);
	import tetris_pkg::*;

	mem_req_t         mem_req;
	mem_req_t         drop_req;
	mem_req_t         clear_req;
	piece_e           drop_piece;
	logic [COL_W-1:0] drop_col;
	logic             drop_go;
	logic             clear_go;
	logic             clr;
	logic             drop_done;
	logic             spawn_fail;
	logic             clear_done;
	logic [2:0]       cleared;

	game_ctrl ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.drop       (drop),
		.piece      (piece),
		.column     (column),
		.restart    (restart),
		.rd_row     (rd_row),
		.drop_req   (drop_req),
		.clear_req  (clear_req),
		.drop_done  (drop_done),
		.spawn_fail (spawn_fail),
		.clear_done (clear_done),
		.cleared    (cleared),
		.drop_go    (drop_go),
		.clear_go   (clear_go),
		.clr        (clr),
		.mem_req    (mem_req),
		.drop_piece (drop_piece),
		.drop_col   (drop_col),
		.busy       (busy),
		.game_over  (game_over),
		.lines      (lines),
		.level      (level)
	);

	piece_dropper dropper_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.go         (drop_go),
		.piece      (drop_piece),
		.column     (drop_col),
		.rd_bits    (rd_bits),
		.req        (drop_req),
		.done       (drop_done),
		.spawn_fail (spawn_fail)
	);

	line_clearer clearer_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (clear_go),
		.rd_bits (rd_bits),
		.req     (clear_req),
		.done    (clear_done),
		.cleared (cleared)
	);

	playfield_ram ram_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.clr     (clr),
		.req     (mem_req),
		.rd_bits (rd_bits) // shared by host and workers
	);

endmodule

// ==== verif/tb_tetris.sv ====
`timescale 1ns/1ps

module tb_tetris;
	import tetris_pkg::*;

	localparam string TRACE_FILE = "verif/tetris_trace.txt";
	localparam int CYCLES_PER_LINE = 200;

	logic               clk;
	logic               rst_n;
	logic               drop;
	piece_e             piece;
	logic [COL_W-1:0]   column;
	logic               restart;
	logic [ROW_W-1:0]   rd_row;
	logic               busy;
	logic               game_over;
	logic [LINES_W-1:0] lines;
	logic [LEVEL_W-1:0] level;
	row_bits_t          rd_bits;

	int cycles = 0;
	int cycle_limit = 0;

	tetris_core dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.drop      (drop),
		.piece     (piece),
		.column    (column),
		.restart   (restart),
		.rd_row    (rd_row),
		.busy      (busy),
		.game_over (game_over),
		.lines     (lines),
		.level     (level),
		.rd_bits   (rd_bits)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			report_failure($sformatf("timeout: the test did not end within %0d cycles", cycles));
	end

	task automatic compare_value(input string name, input int expected, input int actual);
		assert (expected == actual) else
			report_failure($sformatf("FAIL at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic compare_row(input int row, input row_bits_t expected);
		@(posedge clk);
		rd_row <= ROW_W'(row);
		@(negedge clk); // combinational readout settled
		assert (rd_bits == expected) else
			report_failure($sformatf("FAIL at %0t: rd_bits of row %0d expected %b, got %b",
				$time, row, expected, rd_bits));
	endtask

	task automatic expect_empty_board();
		for (int r = 0; r < BOARD_ROWS; r++) begin
			compare_row(r, '0);
		end
	endtask

	task automatic expect_counters(input int exp_lines, input int exp_level, input int exp_over);
		compare_value("lines", exp_lines, int'(lines));
		compare_value("level", exp_level, int'(level));
		compare_value("game_over", exp_over, int'(game_over));
	endtask

	//============================================================
	// command drivers
	//============================================================
	task automatic drop_piece_and_wait(input int p, input int c);
		@(posedge clk);
		drop   <= 1'b1;
		piece  <= piece_e'(p);
		column <= COL_W'(c);
		@(posedge clk);
		drop <= 1'b0;
		@(negedge clk);
		compare_value("busy", 1, int'(busy));
		while (busy) @(negedge clk); // drop and clear in progress
	endtask

	task automatic try_blocked_drop(input int p, input int c);
		@(posedge clk);
		drop   <= 1'b1;
		piece  <= piece_e'(p);
		column <= COL_W'(c);
		@(posedge clk);
		drop <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			compare_value("busy", 0, int'(busy));
		end
		compare_value("game_over", 1, int'(game_over));
	endtask

	task automatic restart_game();
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(negedge clk);
		compare_value("busy", 0, int'(busy));
		expect_counters(0, 0, 0);
		expect_empty_board();
	endtask

	task automatic count_trace_lines(output int n);
		int fd;
		int code;
		logic [8*128-1:0] line;
		n = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
			report_failure("could not open the trace file");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0)
				n++;
		end
		$fclose(fd);
	endtask

	task automatic play_trace();
		int fd;
		int code;
		int p;
		int c;
		int row;
		int exp_lines;
		int exp_level;
		int exp_over;
		logic [7:0] cmd;
		row_bits_t bits;
		logic [8*128-1:0] line;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
			report_failure("could not open the trace file");
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
				break; // end of file
			case (cmd)
				"#": code = $fgets(line, fd);
				"D": begin
					code = $fscanf(fd, "%d %d %d %d %d", p, c, exp_lines, exp_level, exp_over);
					if (code != 5)
						report_failure("a drop line in the trace file is malformed");
					drop_piece_and_wait(p, c);
					expect_counters(exp_lines, exp_level, exp_over);
				end
				"R": begin
					code = $fscanf(fd, "%d %b", row, bits);
					if (code != 2)
						report_failure("a readout line in the trace file is malformed");
					compare_row(row, bits);
				end
				"S": restart_game();
				"I": begin
					code = $fscanf(fd, "%d %d", p, c);
					if (code != 2)
						report_failure("an ignored-drop line in the trace file is malformed");
					try_blocked_drop(p, c);
				end
				default: report_failure("the trace file holds an unknown command");
			endcase
		end
		$fclose(fd);
	endtask

	//============================================================
	// main sequence
	//============================================================
	initial begin
		int n_lines;
		drop    = 1'b0;
		piece   = T;
		column  = '0;
		restart = 1'b0;
		rd_row  = '0;
		rst_n   = 1'b0;
		count_trace_lines(n_lines);
		cycle_limit = CYCLES_PER_LINE * (n_lines + 1); // one extra for reset and sweeps
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_value("busy", 0, int'(busy));
		expect_counters(0, 0, 0);
		expect_empty_board();
		play_trace();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verif/tetris_trace.txt ====
# D piece col lines level over | R row bits (col 9 .. col 0) | S | I piece col
# piece codes T=1 O=2 L=3 J=4 S=5 Z=6 I=7
D 7 0 0 0 0
D 7 4 0 0 0
R 19 0011111111
D 7 0 0 0 0
D 7 4 0 0 0
R 18 0011111111
D 2 8 2 0 0
R 18 0000000000
R 19 0000000000
D 7 0 2 0 0
D 7 4 2 0 0
D 7 0 2 0 0
D 7 4 2 0 0
D 2 8 4 0 0
D 7 0 4 0 0
D 7 4 4 0 0
D 7 0 4 0 0
D 7 4 4 0 0
D 2 8 6 0 0
D 7 0 6 0 0
D 7 4 6 0 0
D 7 0 6 0 0
D 7 4 6 0 0
D 2 8 8 0 0
# fifth round with a T above, rows shift down after the clear
D 7 0 8 0 0
D 7 4 8 0 0
D 7 0 8 0 0
D 7 4 8 0 0
D 1 0 8 0 0
D 2 8 10 1 0
R 17 0000000000
R 18 0000000010
R 19 0000000111
# one of each piece, with clamped columns
D 7 9 10 1 0
R 19 1111000111
D 2 15 10 1 0
R 17 1100000000
R 18 1100000010
D 3 3 11 1 0
R 18 1100000000
R 19 1100100010
D 4 0 11 1 0
D 5 4 11 1 0
D 6 7 11 1 0
D 1 2 11 1 0
R 16 0110001000
R 17 1101111101
R 18 1100110111
R 19 1100100010
# O pieces in column 4 until the spawn is blocked
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 0
D 2 4 11 1 1
I 7 0
R 0 0000000000
R 1 0000110000
R 16 0110111000
S
D 7 0 0 0 0
R 19 0000001111

// ==== sources.f ====
verilog/tetris_pkg.sv
verilog/playfield_ram.sv
verilog/piece_dropper.sv
verilog/line_clearer.sv
verilog/game_ctrl.sv
verilog/tetris_core.sv
verif/tb_tetris.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
TOP        ?= tb_tetris
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
